// File: verilog/csr_pkg.sv
package csr_pkg;

	localparam int XLEN          = 32;                  // Data and address width
	localparam int CSR_ADDR_W    = 12;                  // CSR address space
	localparam int PMP_ENTRIES   = 4;                   // Kept pmpaddr entries
	localparam int PMP_CFG_WORDS = PMP_ENTRIES / 4;     // Four cfg bytes per word
	localparam int MSTATUS_W     = 5;                   // Stored mstatus bits
	localparam int IRQ_W         = 3;                   // Stored mie/mip bits

	// Bit 2 asks for a read, bits 1:0 give the write kind
	typedef enum logic [2:0] {
		CSR_OP_NONE       = 3'b000,
		CSR_OP_SET        = 3'b001,
		CSR_OP_CLEAR      = 3'b010,
		CSR_OP_WRITE      = 3'b011,
		CSR_OP_READ       = 3'b100,
		CSR_OP_READ_SET   = 3'b101,
		CSR_OP_READ_CLEAR = 3'b110,
		CSR_OP_READ_WRITE = 3'b111
	} csr_op_e;

	localparam int CSR_OP_RD_BIT = 2;                   // Read request flag in op

	localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS    = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MISA       = 12'h301;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MIE        = 12'h304;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC      = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC       = 12'h341;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE     = 12'h342;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL      = 12'h343;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MIP        = 12'h344;
	localparam logic [CSR_ADDR_W-1:0] ADDR_PMPCFG0    = 12'h3A0;  // Base of cfg words
	localparam logic [CSR_ADDR_W-1:0] ADDR_PMPADDR0   = 12'h3B0;  // Base of addr entries
	localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID  = 12'hF11;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID    = 12'hF12;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID     = 12'hF13;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID    = 12'hF14;
	localparam logic [CSR_ADDR_W-1:0] ADDR_MCONFIGPTR = 12'hF15;

	// Architectural positions in the 32-bit words
	localparam int MSTATUS_MIE_POS  = 3;
	localparam int MSTATUS_MPIE_POS = 7;
	localparam int MSTATUS_MPP_POS  = 11;
	localparam int MSTATUS_MPRV_POS = 17;
	localparam int MSTATUS_TW_POS   = 21;
	localparam int IRQ_MSI_POS      = 3;
	localparam int IRQ_MTI_POS      = 7;
	localparam int IRQ_MEI_POS      = 11;

	// Positions inside the compact stored vectors
	localparam int MST_MIE_IDX  = 0;
	localparam int MST_MPIE_IDX = 1;
	localparam int MST_MPP_IDX  = 2;
	localparam int MST_MPRV_IDX = 3;
	localparam int MST_TW_IDX   = 4;
	localparam int IRQ_MSI_IDX  = 0;
	localparam int IRQ_MTI_IDX  = 1;
	localparam int IRQ_MEI_IDX  = 2;

	localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h0000_0000;  // Non-commercial
	localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h7FFF_FFFF;
	localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h0000_0001;
	localparam logic [XLEN-1:0] MHARTID_VAL   = 32'h0000_0000;  // Single hart
	localparam logic [XLEN-1:0] MISA_VAL      = 32'h4010_0100;  // RV32 with I and U
	localparam logic [XLEN-1:0] MTVEC_VAL     = 32'h0000_0100;  // Base 0x100, direct mode

	// Software write request, blocked while the trap unit updates
	function automatic logic csr_sw_wr(input logic en, input csr_op_e op, input logic trap_we);
		return en && (op[1:0] != 2'b00) && !trap_we;
	endfunction

	// New register value for the write kind of op
	function automatic logic [XLEN-1:0] csr_merge(input logic [XLEN-1:0] old_val,
	                                              input logic [XLEN-1:0] wdata,
	                                              input csr_op_e op);
		case (op[1:0])
			2'b11:   return wdata;                // Write
			2'b01:   return old_val | wdata;      // Set
			2'b10:   return old_val & ~wdata;     // Clear
			default: return old_val;
		endcase
	endfunction

endpackage

// File: verilog/csr_trap_regs.sv
`timescale 1ns/100ps

module csr_trap_regs import csr_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  csr_en_i,
	input  csr_op_e               csr_op_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  tcu_csr_we_i,      // Trap update strobe
	input  logic [XLEN-1:0]       csr_mtval_i,
	input  logic [XLEN-1:0]       csr_mcause_i,
	input  logic [XLEN-1:0]       csr_mepc_i,
	input  logic [2:0]            csr_trap_state_i,  // MIE, MPIE, MPP
	output logic [MSTATUS_W-1:0]  mstatus_o,         // TW, MPRV, MPP, MPIE, MIE
	output logic [XLEN-1:0]       mepc_o,
	output logic [XLEN-1:0]       mcause_o,
	output logic [XLEN-1:0]       mtval_o
);

	logic [MSTATUS_W-1:0] mstatus_q;
	logic [XLEN-1:0]      mepc_q;
	logic [XLEN-1:0]      mcause_q;
	logic [XLEN-1:0]      mtval_q;
	logic                 sw_wr;          // Software write this cycle
	logic [MSTATUS_W-1:0] mstatus_wbits;  // wdata bits gathered to stored order
	logic [XLEN-1:0]      mstatus_mrg;

	assign sw_wr = csr_sw_wr(csr_en_i, csr_op_i, tcu_csr_we_i);

	assign mstatus_wbits[MST_TW_IDX]   = csr_wdata_i[MSTATUS_TW_POS];
	assign mstatus_wbits[MST_MPRV_IDX] = csr_wdata_i[MSTATUS_MPRV_POS];
	assign mstatus_wbits[MST_MPP_IDX]  = csr_wdata_i[MSTATUS_MPP_POS];
	assign mstatus_wbits[MST_MPIE_IDX] = csr_wdata_i[MSTATUS_MPIE_POS];
	assign mstatus_wbits[MST_MIE_IDX]  = csr_wdata_i[MSTATUS_MIE_POS];

	// Merge on zero-extended vectors, upper bits dropped on store
	assign mstatus_mrg = csr_merge(XLEN'(mstatus_q), XLEN'(mstatus_wbits), csr_op_i);

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			mstatus_q <= '0;
			mepc_q    <= '0;
			mcause_q  <= '0;
			mtval_q   <= '0;
		end else if (tcu_csr_we_i) begin                    // Trap entry or return
			mtval_q                 <= csr_mtval_i;
			mcause_q                <= csr_mcause_i;
			mepc_q                  <= csr_mepc_i;
			mstatus_q[MST_MIE_IDX]  <= csr_trap_state_i[2];
			mstatus_q[MST_MPIE_IDX] <= csr_trap_state_i[1];
			mstatus_q[MST_MPP_IDX]  <= csr_trap_state_i[0];  // TW and MPRV kept
		end else if (sw_wr) begin
			case (csr_addr_i)
				ADDR_MSTATUS: mstatus_q <= mstatus_mrg[MSTATUS_W-1:0];
				ADDR_MEPC:    mepc_q    <= csr_merge(mepc_q, csr_wdata_i, csr_op_i);
				ADDR_MTVAL:   mtval_q   <= csr_merge(mtval_q, csr_wdata_i, csr_op_i);
				default: begin                                // MCAUSE read-only here
				end
			endcase
		end
	end

	assign mstatus_o = mstatus_q;
	assign mepc_o    = mepc_q;
	assign mcause_o  = mcause_q;
	assign mtval_o   = mtval_q;

	// Only the trap unit may move mcause
	mcause_hold_a: assert property (@(posedge clk_i)
		rstn_i && !tcu_csr_we_i |=> $stable(mcause_q))
		else $error("mcause changed on an edge without the trap strobe");

endmodule

// File: verilog/csr_irq_regs.sv
`timescale 1ns/100ps

module csr_irq_regs import csr_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  csr_en_i,
	input  csr_op_e               csr_op_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  tcu_csr_we_i,        // Blocks software writes
	input  logic                  csr_sw_int_pend_i,
	input  logic                  csr_tim_int_pend_i,
	input  logic                  csr_ext_int_pend_i,
	output logic [IRQ_W-1:0]      mie_o,               // MEI, MTI, MSI
	output logic [IRQ_W-1:0]      mip_o                // Same order
);

	logic [IRQ_W-1:0] mie_q;
	logic [IRQ_W-1:0] mip_q;
	logic [IRQ_W-1:0] pend;        // Pending levels in stored order
	logic [IRQ_W-1:0] irq_wbits;   // wdata bits 11, 7, 3
	logic             sw_wr;
	logic             mie_we;
	logic             mip_we;
	logic [XLEN-1:0]  mie_mrg;
	logic [XLEN-1:0]  mip_mrg;

	assign pend[IRQ_MEI_IDX] = csr_ext_int_pend_i;
	assign pend[IRQ_MTI_IDX] = csr_tim_int_pend_i;
	assign pend[IRQ_MSI_IDX] = csr_sw_int_pend_i;

	assign irq_wbits[IRQ_MEI_IDX] = csr_wdata_i[IRQ_MEI_POS];
	assign irq_wbits[IRQ_MTI_IDX] = csr_wdata_i[IRQ_MTI_POS];
	assign irq_wbits[IRQ_MSI_IDX] = csr_wdata_i[IRQ_MSI_POS];

	assign sw_wr  = csr_sw_wr(csr_en_i, csr_op_i, tcu_csr_we_i);
	assign mie_we = sw_wr && (csr_addr_i == ADDR_MIE);
	assign mip_we = sw_wr && (csr_addr_i == ADDR_MIP);

	assign mie_mrg = csr_merge(XLEN'(mie_q), XLEN'(irq_wbits), csr_op_i);
	assign mip_mrg = csr_merge(XLEN'(mip_q), XLEN'(irq_wbits), csr_op_i);

	always_ff @(posedge clk_i) begin
		if (!rstn_i) begin
			mie_q <= '0;
			mip_q <= '0;
		end else begin
			if (mie_we) begin
				mie_q <= mie_mrg[IRQ_W-1:0];
			end
			// Sampled every cycle, a software write wins for one cycle
			mip_q <= mip_we ? mip_mrg[IRQ_W-1:0] : pend;
		end
	end

	assign mie_o = mie_q;
	assign mip_o = mip_q;

	// mip tracks the pending levels one cycle late
	mip_follow_a: assert property (@(posedge clk_i)
		rstn_i && !mip_we |=> mip_q == $past(pend))
		else $error("mip does not match the pending inputs of the previous cycle");

endmodule

// File: verilog/csr_pmp_regs.sv
`timescale 1ns/100ps

module csr_pmp_regs import csr_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  csr_en_i,
	input  csr_op_e               csr_op_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	input  logic                  tcu_csr_we_i,                // Blocks software writes
	output logic [XLEN-1:0]       pmpcfg_o  [PMP_CFG_WORDS],
	output logic [XLEN-1:0]       pmpaddr_o [PMP_ENTRIES]
);

	logic [XLEN-1:0] pmpcfg_q  [PMP_CFG_WORDS];
	logic [XLEN-1:0] pmpaddr_q [PMP_ENTRIES];
	logic            sw_wr;
	logic [(PMP_CFG_WORDS+PMP_ENTRIES)*XLEN-1:0] pmp_flat;  // All words, addr entries low

	assign sw_wr = csr_sw_wr(csr_en_i, csr_op_i, tcu_csr_we_i);

	for (genvar w = 0; w < PMP_CFG_WORDS; w++) begin : g_cfg
		always_ff @(posedge clk_i) begin
			if (!rstn_i) begin
				pmpcfg_q[w] <= '0;
			end else if (sw_wr && csr_addr_i == ADDR_PMPCFG0 + CSR_ADDR_W'(w)) begin
				pmpcfg_q[w] <= csr_merge(pmpcfg_q[w], csr_wdata_i, csr_op_i);
			end
		end
		assign pmpcfg_o[w] = pmpcfg_q[w];
		assign pmp_flat[(PMP_ENTRIES+w)*XLEN +: XLEN] = pmpcfg_q[w];
	end

	// Addresses past the last kept entry match nothing
	for (genvar i = 0; i < PMP_ENTRIES; i++) begin : g_addr
		always_ff @(posedge clk_i) begin
			if (!rstn_i) begin
				pmpaddr_q[i] <= '0;
			end else if (sw_wr && csr_addr_i == ADDR_PMPADDR0 + CSR_ADDR_W'(i)) begin
				pmpaddr_q[i] <= csr_merge(pmpaddr_q[i], csr_wdata_i, csr_op_i);
			end
		end
		assign pmpaddr_o[i] = pmpaddr_q[i];
		assign pmp_flat[i*XLEN +: XLEN] = pmpaddr_q[i];
	end

	// Number of words differing between two snapshots
	function automatic int unsigned words_changed(
		input logic [(PMP_CFG_WORDS+PMP_ENTRIES)*XLEN-1:0] cur,
		input logic [(PMP_CFG_WORDS+PMP_ENTRIES)*XLEN-1:0] prev);
		int unsigned n;
		n = 0;
		for (int k = 0; k < PMP_CFG_WORDS + PMP_ENTRIES; k++) begin
			if (cur[k*XLEN +: XLEN] != prev[k*XLEN +: XLEN]) begin
				n++;
			end
		end
		return n;
	endfunction

	pmp_single_a: assert property (@(posedge clk_i)
		rstn_i |=> words_changed(pmp_flat, $past(pmp_flat)) <= 1)
		else $error("more than one PMP register changed in one cycle");

endmodule

// File: verilog/csr_read_mux.sv
`timescale 1ns/100ps

module csr_read_mux import csr_pkg::*; (
	input  logic                  csr_en_i,
	input  csr_op_e               csr_op_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [MSTATUS_W-1:0]  mstatus_i,
	input  logic [IRQ_W-1:0]      mie_i,
	input  logic [IRQ_W-1:0]      mip_i,
	input  logic [XLEN-1:0]       mepc_i,
	input  logic [XLEN-1:0]       mcause_i,
	input  logic [XLEN-1:0]       mtval_i,
	input  logic [XLEN-1:0]       pmpcfg_i  [PMP_CFG_WORDS],
	input  logic [XLEN-1:0]       pmpaddr_i [PMP_ENTRIES],
	output logic [XLEN-1:0]       csr_rdata_o
);

	logic            rd_req;      // Read asked for this cycle
	logic [XLEN-1:0] mstatus_fmt;
	logic [XLEN-1:0] mie_fmt;
	logic [XLEN-1:0] mip_fmt;
	logic [XLEN-1:0] rdata;

	assign rd_req = csr_en_i && csr_op_i[CSR_OP_RD_BIT];

	// Spread stored bits to architectural positions, rest zero
	always_comb begin
		mstatus_fmt = '0;
		mstatus_fmt[MSTATUS_TW_POS]   = mstatus_i[MST_TW_IDX];
		mstatus_fmt[MSTATUS_MPRV_POS] = mstatus_i[MST_MPRV_IDX];
		mstatus_fmt[MSTATUS_MPP_POS]  = mstatus_i[MST_MPP_IDX];   // Low MPP bit only
		mstatus_fmt[MSTATUS_MPIE_POS] = mstatus_i[MST_MPIE_IDX];
		mstatus_fmt[MSTATUS_MIE_POS]  = mstatus_i[MST_MIE_IDX];
		mie_fmt = '0;
		mie_fmt[IRQ_MEI_POS] = mie_i[IRQ_MEI_IDX];
		mie_fmt[IRQ_MTI_POS] = mie_i[IRQ_MTI_IDX];
		mie_fmt[IRQ_MSI_POS] = mie_i[IRQ_MSI_IDX];
		mip_fmt = '0;
		mip_fmt[IRQ_MEI_POS] = mip_i[IRQ_MEI_IDX];
		mip_fmt[IRQ_MTI_POS] = mip_i[IRQ_MTI_IDX];
		mip_fmt[IRQ_MSI_POS] = mip_i[IRQ_MSI_IDX];
	end

	always_comb begin
		rdata = '0;                                     // Unimplemented reads zero
		if (rd_req) begin
			case (csr_addr_i)
				ADDR_MVENDORID:  rdata = MVENDORID_VAL;
				ADDR_MARCHID:    rdata = MARCHID_VAL;
				ADDR_MIMPID:     rdata = MIMPID_VAL;
				ADDR_MHARTID:    rdata = MHARTID_VAL;
				ADDR_MCONFIGPTR: rdata = '0;            // No config structure
				ADDR_MISA:       rdata = MISA_VAL;
				ADDR_MTVEC:      rdata = MTVEC_VAL;
				ADDR_MSTATUS:    rdata = mstatus_fmt;
				ADDR_MIE:        rdata = mie_fmt;
				ADDR_MIP:        rdata = mip_fmt;
				ADDR_MEPC:       rdata = mepc_i;
				ADDR_MCAUSE:     rdata = mcause_i;
				ADDR_MTVAL:      rdata = mtval_i;
				default: begin
				end
			endcase
			for (int w = 0; w < PMP_CFG_WORDS; w++) begin
				if (csr_addr_i == ADDR_PMPCFG0 + CSR_ADDR_W'(w)) begin
					rdata = pmpcfg_i[w];
				end
			end
			for (int i = 0; i < PMP_ENTRIES; i++) begin  // PMPADDR beyond kept set stays zero
				if (csr_addr_i == ADDR_PMPADDR0 + CSR_ADDR_W'(i)) begin
					rdata = pmpaddr_i[i];
				end
			end
		end
	end

	assign csr_rdata_o = rdata;

endmodule

// File: verilog/csr_regfile_top.sv
`timescale 1ns/100ps

module csr_regfile_top import csr_pkg::*; (
	input  logic                  clk_i,
	input  logic                  rstn_i,
	input  logic                  csr_en_i,            // CSR command
	input  csr_op_e               csr_op_i,
	input  logic [CSR_ADDR_W-1:0] csr_addr_i,
	input  logic [XLEN-1:0]       csr_wdata_i,
	output logic [XLEN-1:0]       csr_rdata_o,
	input  logic                  tcu_csr_we_i,        // Trap update from TCU
	input  logic [XLEN-1:0]       csr_mtval_i,
	input  logic [XLEN-1:0]       csr_mcause_i,
	input  logic [XLEN-1:0]       csr_mepc_i,
	input  logic [2:0]            csr_trap_state_i,    // MIE, MPIE, MPP
	input  logic                  csr_sw_int_pend_i,
	input  logic                  csr_tim_int_pend_i,
	input  logic                  csr_ext_int_pend_i,
	output logic                  csr_mie_o,
	output logic                  csr_mpie_o,
	output logic                  csr_mpp_o,
	output logic                  csr_mprv_o,
	output logic [XLEN-1:0]       csr_mtvec_o,
	output logic [XLEN-1:0]       csr_mepc_o,
	output logic [XLEN-1:0]       csr_mcause_o,
	output logic [XLEN-1:0]       csr_mtval_o,
	output logic [1:0]            csr_ext_int_o,       // {pending, enabled}
	output logic [1:0]            csr_tim_int_o,
	output logic [1:0]            csr_soft_int_o,
	output logic [XLEN-1:0]       csr_pmpcfg_o  [PMP_CFG_WORDS],
	output logic [XLEN-1:0]       csr_pmpaddr_o [PMP_ENTRIES]
);

	logic [MSTATUS_W-1:0] mstatus;
	logic [IRQ_W-1:0]     mie;
	logic [IRQ_W-1:0]     mip;

	csr_trap_regs u_trap (
		.clk_i, .rstn_i, .csr_en_i, .csr_op_i, .csr_addr_i, .csr_wdata_i,
		.tcu_csr_we_i, .csr_mtval_i, .csr_mcause_i, .csr_mepc_i, .csr_trap_state_i,
		.mstatus_o (mstatus),
		.mepc_o    (csr_mepc_o),
		.mcause_o  (csr_mcause_o),
		.mtval_o   (csr_mtval_o)
	);

	csr_irq_regs u_irq (
		.clk_i, .rstn_i, .csr_en_i, .csr_op_i, .csr_addr_i, .csr_wdata_i,
		.tcu_csr_we_i, .csr_sw_int_pend_i, .csr_tim_int_pend_i, .csr_ext_int_pend_i,
		.mie_o (mie),
		.mip_o (mip)
	);

	csr_pmp_regs u_pmp (
		.clk_i, .rstn_i, .csr_en_i, .csr_op_i, .csr_addr_i, .csr_wdata_i, .tcu_csr_we_i,
		.pmpcfg_o  (csr_pmpcfg_o),
		.pmpaddr_o (csr_pmpaddr_o)
	);

	csr_read_mux u_rmux (
		.csr_en_i, .csr_op_i, .csr_addr_i,
		.mstatus_i (mstatus),
		.mie_i     (mie),
		.mip_i     (mip),
		.mepc_i    (csr_mepc_o),
		.mcause_i  (csr_mcause_o),
		.mtval_i   (csr_mtval_o),
		.pmpcfg_i  (csr_pmpcfg_o),
		.pmpaddr_i (csr_pmpaddr_o),
		.csr_rdata_o
	);

	assign csr_mie_o  = mstatus[MST_MIE_IDX];   // Trap state to datapath
	assign csr_mpie_o = mstatus[MST_MPIE_IDX];
	assign csr_mpp_o  = mstatus[MST_MPP_IDX];
	assign csr_mprv_o = mstatus[MST_MPRV_IDX];

	assign csr_mtvec_o = MTVEC_VAL;              // Fixed vector base

	assign csr_ext_int_o  = {mip[IRQ_MEI_IDX], mie[IRQ_MEI_IDX]};
	assign csr_tim_int_o  = {mip[IRQ_MTI_IDX], mie[IRQ_MTI_IDX]};
	assign csr_soft_int_o = {mip[IRQ_MSI_IDX], mie[IRQ_MSI_IDX]};

endmodule

// File: test/csr_regfile_checker.sv
`timescale 1ns/100ps

module csr_regfile_checker import csr_pkg::*; (
	input  logic            clk_i,
	input  logic            rstn_i,
	input  logic [XLEN-1:0] csr_rdata_i,                 // DUT outputs under watch
	input  logic            csr_mie_i,
	input  logic            csr_mpie_i,
	input  logic            csr_mpp_i,
	input  logic            csr_mprv_i,
	input  logic [XLEN-1:0] csr_mtvec_i,
	input  logic [XLEN-1:0] csr_mepc_i,
	input  logic [XLEN-1:0] csr_mcause_i,
	input  logic [XLEN-1:0] csr_mtval_i,
	input  logic [1:0]      csr_ext_int_i,
	input  logic [1:0]      csr_tim_int_i,
	input  logic [1:0]      csr_soft_int_i,
	input  logic [XLEN-1:0] csr_pmpcfg_i  [PMP_CFG_WORDS],
	input  logic [XLEN-1:0] csr_pmpaddr_i [PMP_ENTRIES],
	input  logic            exp_valid_i,                 // Compare on this edge
	input  int              exp_test_i,
	input  logic [XLEN-1:0] exp_rdata_i,
	input  logic [3:0]      exp_sel_i,                   // Which control output to check
	input  logic [XLEN-1:0] exp_out_i,
	input  logic            stim_done_i,
	output int              err_cnt_o,
	output logic            finished_o
);

	localparam int RESET_TIMEOUT = 100;    // Cycles
	localparam int DONE_TIMEOUT  = 4000;

	int pass_cnt  = 0;
	int fail_cnt  = 0;
	int other_cnt = 0;                     // Timeouts and missing results

	assign err_cnt_o = fail_cnt + other_cnt;

	// Control output picked by the selector, packed low
	function automatic logic [XLEN-1:0] observed(input logic [3:0] sel);
		case (sel)
			4'h1:    return {28'b0, csr_mprv_i, csr_mpp_i, csr_mpie_i, csr_mie_i};
			4'h2:    return csr_mepc_i;
			4'h3:    return {26'b0, csr_ext_int_i, csr_tim_int_i, csr_soft_int_i};
			4'h4:    return csr_pmpcfg_i[0];
			4'h5:    return csr_pmpaddr_i[0];
			4'h6:    return csr_pmpaddr_i[1];
			4'h7:    return csr_pmpaddr_i[2];
			4'h8:    return csr_pmpaddr_i[3];
			4'h9:    return csr_mtval_i;
			4'ha:    return csr_mcause_i;
			4'hb:    return csr_mtvec_i;
			default: return '0;
		endcase
	endfunction

	function automatic string observed_name(input logic [3:0] sel);
		case (sel)
			4'h1:    return "{csr_mprv_o,csr_mpp_o,csr_mpie_o,csr_mie_o}";
			4'h2:    return "csr_mepc_o";
			4'h3:    return "{csr_ext_int_o,csr_tim_int_o,csr_soft_int_o}";
			4'h4:    return "csr_pmpcfg_o[0]";
			4'h5:    return "csr_pmpaddr_o[0]";
			4'h6:    return "csr_pmpaddr_o[1]";
			4'h7:    return "csr_pmpaddr_o[2]";
			4'h8:    return "csr_pmpaddr_o[3]";
			4'h9:    return "csr_mtval_o";
			4'ha:    return "csr_mcause_o";
			4'hb:    return "csr_mtvec_o";
			default: return "none";
		endcase
	endfunction

	// Outputs settled since the falling edge, NBAs not yet applied
	always @(posedge clk_i) begin
		if (exp_valid_i) begin
			if (csr_rdata_i !== exp_rdata_i) begin
				$display("error time %0t test %0d csr_rdata_o expected %h actual %h",
				         $time, exp_test_i, exp_rdata_i, csr_rdata_i);
				fail_cnt++;
			end else if (exp_sel_i != 4'h0 && observed(exp_sel_i) !== exp_out_i) begin
				$display("error time %0t test %0d %s expected %h actual %h", $time,
				         exp_test_i, observed_name(exp_sel_i), exp_out_i, observed(exp_sel_i));
				fail_cnt++;
			end else begin
				$display("test %0d passed", exp_test_i);
				pass_cnt++;
			end
		end
	end

	initial begin : supervise
		int cyc;
		finished_o = 1'b0;
		cyc = 0;
		while (rstn_i !== 1'b1 && cyc < RESET_TIMEOUT) begin
			@(posedge clk_i);
			cyc++;
		end
		if (rstn_i !== 1'b1) begin
			$display("reset was not released within %0d cycles", RESET_TIMEOUT);
			other_cnt++;
		end
		cyc = 0;
		while (stim_done_i !== 1'b1 && cyc < DONE_TIMEOUT) begin
			@(posedge clk_i);
			cyc++;
		end
		if (stim_done_i !== 1'b1) begin
			$display("stimulus did not reach the end of its file within %0d cycles",
			         DONE_TIMEOUT);
			other_cnt++;
		end
		if (pass_cnt + fail_cnt == 0) begin
			$display("no test results were seen");
			other_cnt++;
		end
		$display("tests %0d passed %0d failed %0d other errors %0d",
		         pass_cnt + fail_cnt, pass_cnt, fail_cnt, other_cnt);
		finished_o = 1'b1;
	end

endmodule

// File: test/tb_csr_regfile.sv
`timescale 1ns/100ps

module tb_csr_regfile import csr_pkg::*; ();

	localparam int    CLK_PERIOD  = 40;         // ns
	localparam int    RST_CYCLES  = 10;
	localparam int    RUN_TIMEOUT = 5000;       // Cycles before the run is abandoned
	localparam string STIM_FILE   = "test/csr_regfile_input.txt";

	logic                  clk;
	logic                  rstn;
	logic                  csr_en;
	csr_op_e               csr_op;
	logic [CSR_ADDR_W-1:0] csr_addr;
	logic [XLEN-1:0]       csr_wdata;
	logic                  tcu_we;
	logic [XLEN-1:0]       trap_mtval;
	logic [XLEN-1:0]       trap_mcause;
	logic [XLEN-1:0]       trap_mepc;
	logic [2:0]            trap_state;          // MIE, MPIE, MPP
	logic                  sw_pend;
	logic                  tim_pend;
	logic                  ext_pend;
	logic [XLEN-1:0]       rdata;
	logic                  st_mie;
	logic                  st_mpie;
	logic                  st_mpp;
	logic                  st_mprv;
	logic [XLEN-1:0]       mtvec;
	logic [XLEN-1:0]       mepc;
	logic [XLEN-1:0]       mcause;
	logic [XLEN-1:0]       mtval;
	logic [1:0]            ext_int;
	logic [1:0]            tim_int;
	logic [1:0]            soft_int;
	logic [XLEN-1:0]       pmpcfg  [PMP_CFG_WORDS];
	logic [XLEN-1:0]       pmpaddr [PMP_ENTRIES];

	logic                  exp_valid;           // Checker compares on the next rise
	int                    exp_test;
	logic [XLEN-1:0]       exp_rdata;
	logic [3:0]            exp_sel;
	logic [XLEN-1:0]       exp_out;
	logic                  stim_done;
	int                    stim_err;            // File problems
	int                    err_cnt;
	logic                  chk_finished;

	csr_regfile_top uut (
		.clk_i (clk), .rstn_i (rstn),
		.csr_en_i (csr_en), .csr_op_i (csr_op), .csr_addr_i (csr_addr),
		.csr_wdata_i (csr_wdata), .csr_rdata_o (rdata),
		.tcu_csr_we_i (tcu_we), .csr_mtval_i (trap_mtval), .csr_mcause_i (trap_mcause),
		.csr_mepc_i (trap_mepc), .csr_trap_state_i (trap_state),
		.csr_sw_int_pend_i (sw_pend), .csr_tim_int_pend_i (tim_pend),
		.csr_ext_int_pend_i (ext_pend),
		.csr_mie_o (st_mie), .csr_mpie_o (st_mpie), .csr_mpp_o (st_mpp), .csr_mprv_o (st_mprv),
		.csr_mtvec_o (mtvec), .csr_mepc_o (mepc), .csr_mcause_o (mcause), .csr_mtval_o (mtval),
		.csr_ext_int_o (ext_int), .csr_tim_int_o (tim_int), .csr_soft_int_o (soft_int),
		.csr_pmpcfg_o (pmpcfg), .csr_pmpaddr_o (pmpaddr)
	);

	csr_regfile_checker u_checker (
		.clk_i (clk), .rstn_i (rstn), .csr_rdata_i (rdata),
		.csr_mie_i (st_mie), .csr_mpie_i (st_mpie), .csr_mpp_i (st_mpp), .csr_mprv_i (st_mprv),
		.csr_mtvec_i (mtvec), .csr_mepc_i (mepc), .csr_mcause_i (mcause), .csr_mtval_i (mtval),
		.csr_ext_int_i (ext_int), .csr_tim_int_i (tim_int), .csr_soft_int_i (soft_int),
		.csr_pmpcfg_i (pmpcfg), .csr_pmpaddr_i (pmpaddr),
		.exp_valid_i (exp_valid), .exp_test_i (exp_test), .exp_rdata_i (exp_rdata),
		.exp_sel_i (exp_sel), .exp_out_i (exp_out), .stim_done_i (stim_done),
		.err_cnt_o (err_cnt), .finished_o (chk_finished)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Write cycle, trap strobe and pending levels for one test
	task automatic drive_command(input logic [2:0] op, input logic [CSR_ADDR_W-1:0] addr,
		input logic [XLEN-1:0] wdata, input logic twe, input logic [XLEN-1:0] tval,
		input logic [XLEN-1:0] tcause, input logic [XLEN-1:0] tepc, input logic [2:0] tstate,
		input logic [2:0] pend);
		@(negedge clk);
		exp_valid   = 1'b0;
		csr_en      = 1'b1;
		csr_op      = csr_op_e'(op);
		csr_addr    = addr;
		csr_wdata   = wdata;
		tcu_we      = twe;
		trap_mtval  = tval;
		trap_mcause = tcause;
		trap_mepc   = tepc;
		trap_state  = tstate;
		{ext_pend, tim_pend, sw_pend} = pend;       // Held until the next test
	endtask

	// Read back the same address, expectations go to the checker
	task automatic request_read(input int tnum, input logic ren, input logic [2:0] rop,
		input logic [XLEN-1:0] rdata_exp, input logic [3:0] sel, input logic [XLEN-1:0] out_exp);
		@(negedge clk);
		csr_en      = ren;
		csr_op      = csr_op_e'(rop);
		csr_wdata   = '0;
		tcu_we      = 1'b0;
		trap_mtval  = '0;
		trap_mcause = '0;
		trap_mepc   = '0;
		trap_state  = '0;
		exp_test    = tnum;
		exp_rdata   = rdata_exp;
		exp_sel     = sel;
		exp_out     = out_exp;
		exp_valid   = 1'b1;
	endtask

	initial begin : stimulus
		int                    fd;
		int                    n;
		string                 line;
		int                    tnum;
		logic [2:0]            op;
		logic [CSR_ADDR_W-1:0] addr;
		logic [XLEN-1:0]       wdata;
		logic                  twe;
		logic [XLEN-1:0]       tval;
		logic [XLEN-1:0]       tcause;
		logic [XLEN-1:0]       tepc;
		logic [2:0]            tstate;
		logic [2:0]            pend;
		logic                  ren;
		logic [2:0]            rop;
		logic [XLEN-1:0]       rdata_exp;
		logic [3:0]            sel;
		logic [XLEN-1:0]       out_exp;
		rstn        = 1'b0;
		csr_en      = 1'b0;
		csr_op      = CSR_OP_NONE;
		csr_addr    = '0;
		csr_wdata   = '0;
		tcu_we      = 1'b0;
		trap_mtval  = '0;
		trap_mcause = '0;
		trap_mepc   = '0;
		trap_state  = '0;
		sw_pend     = 1'b0;
		tim_pend    = 1'b0;
		ext_pend    = 1'b0;
		exp_valid   = 1'b0;
		exp_test    = 0;
		exp_rdata   = '0;
		exp_sel     = '0;
		exp_out     = '0;
		stim_done   = 1'b0;
		stim_err    = 0;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("stimulus file %s could not be opened", STIM_FILE);
			stim_err++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				            tnum, op, addr, wdata, twe, tval, tcause, tepc, tstate, pend,
				            ren, rop, rdata_exp, sel, out_exp);
				if (n == 15) begin
					drive_command(op, addr, wdata, twe, tval, tcause, tepc, tstate, pend);
					request_read(tnum, ren, rop, rdata_exp, sel, out_exp);
				end else if (n > 0) begin                 // Comments and blank lines give 0
					$display("stimulus line with %0d fields skipped", n);
					stim_err++;
				end
			end
			$fclose(fd);
		end
		@(negedge clk);
		exp_valid = 1'b0;
		csr_en    = 1'b0;
		csr_op    = CSR_OP_NONE;
		stim_done = 1'b1;
	end

	initial begin : end_of_run
		int cyc;
		cyc = 0;
		while (chk_finished !== 1'b1 && cyc < RUN_TIMEOUT) begin
			@(posedge clk);
			cyc++;
		end
		if (chk_finished !== 1'b1) begin
			$display("checker did not finish within %0d cycles", RUN_TIMEOUT);
			$display("Finished with errors");
		end else if (err_cnt == 0 && stim_err == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: csr_regfile.f
verilog/csr_pkg.sv
verilog/csr_trap_regs.sv
verilog/csr_irq_regs.sv
verilog/csr_pmp_regs.sv
verilog/csr_read_mux.sv
verilog/csr_regfile_top.sv
test/csr_regfile_checker.sv
test/tb_csr_regfile.sv

// File: Makefile
# Verilator flow for the csr_regfile testbench
TOP       ?= tb_csr_regfile
RTL_TOP   ?= csr_regfile_top
FILELIST  ?= csr_regfile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter verilog/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: test/csr_regfile_input.txt
# test op addr wdata twe mtval mcause mepc tstate(MIE,MPIE,MPP) pend(ext,tim,sw)
# ren rop exp_rdata sel exp_out   (sel 1 mstatus 2 mepc 3 irq 4 cfg0 5-8 addr0-3 9 mtval a mcause b mtvec)
1 3 341 12345678 0 00000000 00000000 00000000 0 0 1 4 12345678 2 12345678
2 1 341 0000F00F 0 00000000 00000000 00000000 0 0 1 4 1234F67F 2 1234F67F
3 2 341 12000000 0 00000000 00000000 00000000 0 0 1 4 0034F67F 2 0034F67F
4 7 343 A5A5A5A5 0 00000000 00000000 00000000 0 0 1 4 A5A5A5A5 9 A5A5A5A5
5 5 343 0F0F0000 0 00000000 00000000 00000000 0 0 1 4 AFAFA5A5 9 AFAFA5A5
6 6 343 FFFF0000 0 00000000 00000000 00000000 0 0 1 4 0000A5A5 9 0000A5A5
7 3 300 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00220888 1 0000000F
8 2 300 00000088 0 00000000 00000000 00000000 0 0 1 4 00220800 1 0000000C
9 3 301 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 40100100 0 00000000
10 3 F11 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000000 0 00000000
11 3 F12 00000000 0 00000000 00000000 00000000 0 0 1 4 7FFFFFFF 0 00000000
12 3 F13 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000001 0 00000000
13 3 F14 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000000 0 00000000
14 3 305 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000100 b 00000100
15 3 F15 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000000 0 00000000
16 3 7C0 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000000 0 00000000
17 0 341 00000000 0 00000000 00000000 00000000 0 0 0 4 00000000 2 0034F67F
18 0 341 00000000 0 00000000 00000000 00000000 0 0 1 0 00000000 2 0034F67F
19 3 341 DEADBEEF 1 00000BAD 8000000B 00000200 2 0 1 4 00000200 1 0000000A
20 3 342 00000000 0 00000000 00000000 00000000 0 0 1 4 8000000B a 8000000B
21 4 300 00000000 0 00000000 00000000 00000000 0 0 1 4 00220080 9 00000BAD
22 3 3B0 FFFFFFFF 1 00000BAD 8000000B 00000200 2 0 1 4 00000000 5 00000000
23 3 304 00000888 0 00000000 00000000 00000000 0 7 1 4 00000888 3 0000003F
24 4 344 00000000 0 00000000 00000000 00000000 0 5 1 4 00000808 3 00000037
25 2 304 00000800 0 00000000 00000000 00000000 0 2 1 4 00000088 3 0000000D
26 3 344 00000008 0 00000000 00000000 00000000 0 0 1 4 00000008 3 00000007
27 4 344 00000000 0 00000000 00000000 00000000 0 0 1 4 00000000 3 00000005
28 3 3A0 1F0F0701 0 00000000 00000000 00000000 0 0 1 4 1F0F0701 4 1F0F0701
29 1 3A0 00000018 0 00000000 00000000 00000000 0 0 1 4 1F0F0719 4 1F0F0719
30 3 3B0 11111111 0 00000000 00000000 00000000 0 0 1 4 11111111 5 11111111
31 3 3B1 22222222 0 00000000 00000000 00000000 0 0 1 4 22222222 6 22222222
32 3 3B2 33333333 0 00000000 00000000 00000000 0 0 1 4 33333333 7 33333333
33 1 3B3 44440000 0 00000000 00000000 00000000 0 0 1 4 44440000 8 44440000
34 2 3B3 40000000 0 00000000 00000000 00000000 0 0 1 4 04440000 8 04440000
35 3 3B4 FFFFFFFF 0 00000000 00000000 00000000 0 0 1 4 00000000 8 04440000
